/* hw/cmd_fifo.sv */
// Register-based beat queue, QUEUE_DEPTH must be a power of two and at least 2
// A beat written on one edge is readable on the next cycle
// Either reset flushes the contents
`default_nettype none

module cmd_fifo #(
  parameter int unsigned QUEUE_DEPTH = 16
) (
  input  wire                        i_clk_core,
  input  wire                        i_rst_core,
  input  wire                        i_usr_rst,
  input  wire ctl_stream_pkg::ctl_beat_t i_wr,
  input  wire                        i_wr_val,
  output logic                       o_wr_rdy,
  output ctl_stream_pkg::ctl_beat_t  o_rd,
  output logic                       o_rd_val,
  input  wire                        i_rd_rdy
);
  import ctl_stream_pkg::*;

  localparam int unsigned AW = $clog2(QUEUE_DEPTH);

  typedef logic [AW-1:0] ptr_t;
  typedef logic [AW:0] cnt_t;

  ctl_beat_t mem [QUEUE_DEPTH];
  ptr_t wr_ptr, rd_ptr;
  cnt_t count;
  logic wr_fire, rd_fire;

  assign o_wr_rdy = (count != cnt_t'(QUEUE_DEPTH));
  assign o_rd_val = (count != '0);
  assign o_rd = mem[rd_ptr];
  assign wr_fire = i_wr_val && o_wr_rdy;
  assign rd_fire = o_rd_val && i_rd_rdy;

  always_ff @(posedge i_clk_core) begin
    if (wr_fire) begin
      mem[wr_ptr] <= i_wr;
    end
  end

  always_ff @(posedge i_clk_core) begin
    if (i_rst_core || i_usr_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_fire) wr_ptr <= wr_ptr + ptr_t'(1);
      if (rd_fire) rd_ptr <= rd_ptr + ptr_t'(1);
      case ({wr_fire, rd_fire})
        2'b10: count <= count + cnt_t'(1);
        2'b01: count <= count - cnt_t'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/cmd_router.sv */
// Sorts host packets into the system or verify queue by message type
// The type is read from the sop beat and held until the packet ends
// o_cmd_rdy depends combinationally on the offered beat
`default_nettype none

module cmd_router #(
  parameter int unsigned QUEUE_DEPTH = 16
) (
  input  wire                        i_clk_core,
  input  wire                        i_rst_core,
  input  wire                        i_usr_rst,
  input  wire ctl_stream_pkg::ctl_beat_t i_cmd,
  input  wire                        i_cmd_val,
  output logic                       o_cmd_rdy,
  output ctl_stream_pkg::ctl_beat_t  o_sys,
  output logic                       o_sys_val,
  input  wire                        i_sys_rdy,
  output ctl_stream_pkg::ctl_beat_t  o_ver,
  output logic                       o_ver_val,
  input  wire                        i_ver_rdy
);
  import ctl_msg_pkg::*;

  msg_hdr_t hdr;
  logic route_ver, route_ver_l;
  logic sys_wr_rdy, ver_wr_rdy;

  assign hdr = msg_hdr_t'(i_cmd.dat);

  // Nonzero message type goes to the verify queue
  assign route_ver = i_cmd.sop ? (hdr.cmd[15:8] != 8'h00) : route_ver_l;
  assign o_cmd_rdy = route_ver ? ver_wr_rdy : sys_wr_rdy;

  always_ff @(posedge i_clk_core) begin
    if (i_rst_core || i_usr_rst) begin
      route_ver_l <= 1'b0;
    end else if (i_cmd_val && o_cmd_rdy) begin
      route_ver_l <= route_ver;
    end
  end

  cmd_fifo #(.QUEUE_DEPTH(QUEUE_DEPTH)) sys_fifo_i (
    .i_clk_core(i_clk_core),
    .i_rst_core(i_rst_core),
    .i_usr_rst(i_usr_rst),
    .i_wr(i_cmd),
    .i_wr_val(i_cmd_val && !route_ver),
    .o_wr_rdy(sys_wr_rdy),
    .o_rd(o_sys),
    .o_rd_val(o_sys_val),
    .i_rd_rdy(i_sys_rdy)
  );

  cmd_fifo #(.QUEUE_DEPTH(QUEUE_DEPTH)) ver_fifo_i (
    .i_clk_core(i_clk_core),
    .i_rst_core(i_rst_core),
    .i_usr_rst(i_usr_rst),
    .i_wr(i_cmd),
    .i_wr_val(i_cmd_val && route_ver),
    .o_wr_rdy(ver_wr_rdy),
    .o_rd(o_ver),
    .o_rd_val(o_ver_val),
    .i_rd_rdy(i_ver_rdy)
  );

endmodule

`default_nettype wire

/* hw/ctl_msg_pkg.sv */
// Message layouts for host commands and replies
// Every packet starts with a 64-bit header; the upper command byte is the message type
// Reply structs are declared high field first so the header lands in beat 0
`default_nettype none

package ctl_msg_pkg;

  typedef logic [15:0] msg_cmd_t;
  typedef logic [63:0] job_index_t;
  typedef logic [15:0] result_mask_t;

  // Type 0 commands
  localparam msg_cmd_t CMD_RESET = 16'h0000;
  localparam msg_cmd_t CMD_STATUS = 16'h0001;
  // Type 1 commands
  localparam msg_cmd_t CMD_VERIFY = 16'h0100;

  localparam msg_cmd_t RPL_RESET = 16'h0080;
  localparam msg_cmd_t RPL_STATUS = 16'h0081;
  localparam msg_cmd_t RPL_VERIFY = 16'h0180;

  typedef struct packed {
    logic [31:0] rsv;
    msg_cmd_t cmd;
    logic [15:0] len;
  } msg_hdr_t;

  typedef struct packed {
    logic [31:0] build_date;
    logic [63:0] build_host;
    msg_hdr_t hdr;
  } status_rpl_t;

  typedef struct packed {
    msg_hdr_t hdr;
  } reset_rpl_t;

  typedef struct packed {
    logic [63:0] mask;
    job_index_t index;
    msg_hdr_t hdr;
  } verify_rpl_t;

  localparam int unsigned STATUS_RPL_BYTES = $bits(status_rpl_t) / 8;
  localparam int unsigned RESET_RPL_BYTES = $bits(reset_rpl_t) / 8;
  localparam int unsigned VERIFY_RPL_BYTES = $bits(verify_rpl_t) / 8;

  typedef enum logic [1:0] {SYS_IDLE, SYS_RESET, SYS_REPLY, SYS_DISCARD} sys_state_t;

  typedef enum logic [2:0] {
    VER_IDLE, VER_INDEX, VER_FEED, VER_WAIT, VER_REPLY, VER_DISCARD
  } ver_state_t;

  function automatic msg_hdr_t rpl_hdr(msg_cmd_t cmd, int unsigned nbytes);
    msg_hdr_t h;
    h.rsv = '0;
    h.cmd = cmd;
    h.len = 16'(nbytes);
    return h;
  endfunction

endpackage

`default_nettype wire

/* hw/ctl_stream_pkg.sv */
// Beat-level stream types shared by every port of the controller
// Beats are 8 bytes wide with byte 0 in the low bits; mod 0 means all 8 bytes valid
`default_nettype none

package ctl_stream_pkg;

  localparam int unsigned BEAT_BYTES = 8;
  localparam int unsigned BEAT_BITS = BEAT_BYTES * 8;

  typedef logic [BEAT_BITS-1:0] beat_dat_t;
  typedef logic [2:0] beat_mod_t;
  // Remaining bytes of a packet being serialized
  typedef logic [7:0] byte_cnt_t;

  typedef struct packed {
    beat_dat_t dat;
    logic sop;
    logic eop;
    beat_mod_t mod;
  } ctl_beat_t;

  // Forms one outgoing beat from the low word of a shift register
  function automatic ctl_beat_t sr_beat(beat_dat_t dat, logic first, byte_cnt_t left);
    ctl_beat_t b;
    b.dat = dat;
    b.sop = first;
    b.eop = (left <= 8'd8);
    b.mod = b.eop ? beat_mod_t'(left[2:0]) : '0;
    return b;
  endfunction

endpackage

`default_nettype wire

/* hw/ctl_top.sv */
// Command and reply controller for the hash-verification engine
// Single clock; the engine sits outside and answers each job with one mask strobe
// o_usr_rst also flushes the command queues and the reply arbiter
`default_nettype none

module ctl_top #(
  parameter int unsigned QUEUE_DEPTH = 16,
  parameter int unsigned RST_CYCLES = 8,
  parameter logic [63:0] BUILD_HOST = "ctl_host",
  parameter logic [31:0] BUILD_DATE = 32'h0000_0000
) (
  input  wire                          i_clk_core,
  input  wire                          i_rst_core,
  input  wire ctl_stream_pkg::ctl_beat_t   i_cmd,
  input  wire                          i_cmd_val,
  output logic                         o_cmd_rdy,
  output ctl_stream_pkg::ctl_beat_t    o_rpl,
  output logic                         o_rpl_val,
  input  wire                          i_rpl_rdy,
  output ctl_stream_pkg::ctl_beat_t    o_job,
  output logic                         o_job_val,
  input  wire                          i_job_rdy,
  input  wire ctl_msg_pkg::result_mask_t i_result_mask,
  input  wire                          i_result_val,
  output logic                         o_usr_rst
);
  import ctl_stream_pkg::*;

  ctl_beat_t sys_q, ver_q, sys_rpl, ver_rpl;
  logic sys_q_val, sys_q_rdy, ver_q_val, ver_q_rdy;
  logic sys_rpl_val, sys_rpl_rdy, ver_rpl_val, ver_rpl_rdy;

  cmd_router #(.QUEUE_DEPTH(QUEUE_DEPTH)) cmd_router_i (
    .i_clk_core(i_clk_core), .i_rst_core(i_rst_core), .i_usr_rst(o_usr_rst),
    .i_cmd(i_cmd), .i_cmd_val(i_cmd_val), .o_cmd_rdy(o_cmd_rdy),
    .o_sys(sys_q), .o_sys_val(sys_q_val), .i_sys_rdy(sys_q_rdy),
    .o_ver(ver_q), .o_ver_val(ver_q_val), .i_ver_rdy(ver_q_rdy)
  );

  sys_cmd_proc #(
    .RST_CYCLES(RST_CYCLES), .BUILD_HOST(BUILD_HOST), .BUILD_DATE(BUILD_DATE)
  ) sys_cmd_proc_i (
    .i_clk_core(i_clk_core), .i_rst_core(i_rst_core),
    .i_cmd(sys_q), .i_cmd_val(sys_q_val), .o_cmd_rdy(sys_q_rdy),
    .o_rpl(sys_rpl), .o_rpl_val(sys_rpl_val), .i_rpl_rdy(sys_rpl_rdy),
    .o_usr_rst(o_usr_rst)
  );

  verify_cmd_proc verify_cmd_proc_i (
    .i_clk_core(i_clk_core), .i_rst_core(i_rst_core), .i_usr_rst(o_usr_rst),
    .i_cmd(ver_q), .i_cmd_val(ver_q_val), .o_cmd_rdy(ver_q_rdy),
    .o_job(o_job), .o_job_val(o_job_val), .i_job_rdy(i_job_rdy),
    .i_result_mask(i_result_mask), .i_result_val(i_result_val),
    .o_rpl(ver_rpl), .o_rpl_val(ver_rpl_val), .i_rpl_rdy(ver_rpl_rdy)
  );

  reply_arb reply_arb_i (
    .i_clk_core(i_clk_core), .i_rst_core(i_rst_core), .i_usr_rst(o_usr_rst),
    .i_sys(sys_rpl), .i_sys_val(sys_rpl_val), .o_sys_rdy(sys_rpl_rdy),
    .i_ver(ver_rpl), .i_ver_val(ver_rpl_val), .o_ver_rdy(ver_rpl_rdy),
    .o_rpl(o_rpl), .o_rpl_val(o_rpl_val), .i_rpl_rdy(i_rpl_rdy)
  );

endmodule

`default_nettype wire

/* hw/reply_arb.sv */
// Two-input packet arbiter with no added latency
// Once a source is offered it stays selected until its eop beat is accepted
// When both wait, the source that did not win last goes first
`default_nettype none

module reply_arb (
  input  wire                        i_clk_core,
  input  wire                        i_rst_core,
  input  wire                        i_usr_rst,
  input  wire ctl_stream_pkg::ctl_beat_t i_sys,
  input  wire                        i_sys_val,
  output logic                       o_sys_rdy,
  input  wire ctl_stream_pkg::ctl_beat_t i_ver,
  input  wire                        i_ver_val,
  output logic                       o_ver_rdy,
  output ctl_stream_pkg::ctl_beat_t  o_rpl,
  output logic                       o_rpl_val,
  input  wire                        i_rpl_rdy
);
  // Select and grant encoding is 1 for the verify source
  logic sel, grant, locked, last;

  always_comb begin
    if (locked) begin
      sel = grant;
    end else if (i_sys_val && i_ver_val) begin
      sel = !last;
    end else begin
      sel = i_ver_val;
    end
  end

  assign o_rpl = sel ? i_ver : i_sys;
  assign o_rpl_val = sel ? i_ver_val : i_sys_val;
  assign o_sys_rdy = !sel && i_rpl_rdy;
  assign o_ver_rdy = sel && i_rpl_rdy;

  always_ff @(posedge i_clk_core) begin
    if (i_rst_core || i_usr_rst) begin
      locked <= 1'b0;
      grant <= 1'b0;
      last <= 1'b0;
    end else if (o_rpl_val) begin
      if (i_rpl_rdy && o_rpl.eop) begin
        locked <= 1'b0;
        last <= sel;
      end else begin
        // Stalled or mid-packet, keep this source on the output
        locked <= 1'b1;
        grant <= sel;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/sys_cmd_proc.sv */
// Type 0 handler for status and user reset commands
// Not cleared by the user reset it generates, so the reset reply survives the pulse
// Non-sop beats seen while idle are dropped, unknown commands give no reply
`default_nettype none

module sys_cmd_proc #(
  parameter int unsigned RST_CYCLES = 8,
  parameter logic [63:0] BUILD_HOST = "ctl_host",
  parameter logic [31:0] BUILD_DATE = 32'h0000_0000
) (
  input  wire                        i_clk_core,
  input  wire                        i_rst_core,
  input  wire ctl_stream_pkg::ctl_beat_t i_cmd,
  input  wire                        i_cmd_val,
  output logic                       o_cmd_rdy,
  output ctl_stream_pkg::ctl_beat_t  o_rpl,
  output logic                       o_rpl_val,
  input  wire                        i_rpl_rdy,
  output logic                       o_usr_rst
);
  import ctl_stream_pkg::*;
  import ctl_msg_pkg::*;

  localparam int unsigned SR_W = $bits(status_rpl_t);
  localparam int unsigned RW = $clog2(RST_CYCLES + 1);

  typedef logic [RW-1:0] rst_cnt_t;

  localparam status_rpl_t STATUS_RPL = {BUILD_DATE, BUILD_HOST,
                                        rpl_hdr(RPL_STATUS, STATUS_RPL_BYTES)};
  localparam reset_rpl_t RESET_RPL = rpl_hdr(RPL_RESET, RESET_RPL_BYTES);

  sys_state_t state;
  msg_hdr_t hdr;
  logic cmd_fire, rpl_fire;
  logic [SR_W-1:0] rpl_sr;
  byte_cnt_t rpl_left;
  logic rpl_first;
  rst_cnt_t rst_cnt;

  assign hdr = msg_hdr_t'(i_cmd.dat);
  assign o_cmd_rdy = (state == SYS_IDLE) || (state == SYS_DISCARD);
  assign cmd_fire = i_cmd_val && o_cmd_rdy;
  assign o_rpl_val = (state == SYS_REPLY);
  assign o_rpl = sr_beat(rpl_sr[BEAT_BITS-1:0], rpl_first, rpl_left);
  assign rpl_fire = o_rpl_val && i_rpl_rdy;

  always_ff @(posedge i_clk_core) begin
    if (i_rst_core) begin
      state <= SYS_IDLE;
      o_usr_rst <= 1'b0;
      rst_cnt <= '0;
    end else begin
      case (state)
        SYS_IDLE: begin
          if (cmd_fire && i_cmd.sop) begin
            case (hdr.cmd)
              CMD_STATUS: state <= SYS_REPLY;
              CMD_RESET: begin
                state <= SYS_RESET;
                o_usr_rst <= 1'b1;
                rst_cnt <= rst_cnt_t'(RST_CYCLES - 1);
              end
              default: if (!i_cmd.eop) state <= SYS_DISCARD;
            endcase
          end
        end
        SYS_RESET: begin
          // Reply is offered on the cycle the pulse drops
          if (rst_cnt == '0) begin
            o_usr_rst <= 1'b0;
            state <= SYS_REPLY;
          end else begin
            rst_cnt <= rst_cnt - rst_cnt_t'(1);
          end
        end
        SYS_REPLY: if (rpl_fire && o_rpl.eop) state <= SYS_IDLE;
        SYS_DISCARD: if (cmd_fire && i_cmd.eop) state <= SYS_IDLE;
        default: state <= SYS_IDLE;
      endcase
    end
  end

  // Reply shift register, loaded on the header and drained one beat per transfer
  always_ff @(posedge i_clk_core) begin
    if (state == SYS_IDLE && cmd_fire && i_cmd.sop) begin
      rpl_first <= 1'b1;
      if (hdr.cmd == CMD_RESET) begin
        rpl_sr <= SR_W'(RESET_RPL);
        rpl_left <= byte_cnt_t'(RESET_RPL_BYTES);
      end else begin
        rpl_sr <= STATUS_RPL;
        rpl_left <= byte_cnt_t'(STATUS_RPL_BYTES);
      end
    end else if (rpl_fire) begin
      rpl_first <= 1'b0;
      rpl_sr <= rpl_sr >> BEAT_BITS;
      rpl_left <= rpl_left - 8'd8;
    end
  end

endmodule

`default_nettype wire

/* hw/verify_cmd_proc.sv */
// Type 1 handler: header, then index beat, then job payload passed to the engine
// Only one job is in flight; the next command waits in its queue until the reply is sent
// A verify packet with no payload after the index is dropped without a reply
`default_nettype none

module verify_cmd_proc (
  input  wire                          i_clk_core,
  input  wire                          i_rst_core,
  input  wire                          i_usr_rst,
  input  wire ctl_stream_pkg::ctl_beat_t   i_cmd,
  input  wire                          i_cmd_val,
  output logic                         o_cmd_rdy,
  output ctl_stream_pkg::ctl_beat_t    o_job,
  output logic                         o_job_val,
  input  wire                          i_job_rdy,
  input  wire ctl_msg_pkg::result_mask_t i_result_mask,
  input  wire                          i_result_val,
  output ctl_stream_pkg::ctl_beat_t    o_rpl,
  output logic                         o_rpl_val,
  input  wire                          i_rpl_rdy
);
  import ctl_stream_pkg::*;
  import ctl_msg_pkg::*;

  localparam int unsigned SR_W = $bits(verify_rpl_t);

  ver_state_t state;
  msg_hdr_t hdr;
  verify_rpl_t ver_rpl;
  job_index_t index_q;
  logic cmd_fire, rpl_fire, job_first;
  logic [SR_W-1:0] rpl_sr;
  byte_cnt_t rpl_left;
  logic rpl_first;

  assign hdr = msg_hdr_t'(i_cmd.dat);

  always_comb begin
    case (state)
      VER_FEED: o_cmd_rdy = i_job_rdy;
      VER_WAIT, VER_REPLY: o_cmd_rdy = 1'b0;
      default: o_cmd_rdy = 1'b1;
    endcase
  end

  assign cmd_fire = i_cmd_val && o_cmd_rdy;

  // Payload passes straight through during the feed
  always_comb begin
    o_job = i_cmd;
    o_job.sop = job_first;
  end
  assign o_job_val = (state == VER_FEED) && i_cmd_val;

  always_comb begin
    ver_rpl.hdr = rpl_hdr(RPL_VERIFY, VERIFY_RPL_BYTES);
    ver_rpl.index = index_q;
    ver_rpl.mask = 64'(i_result_mask);
  end

  assign o_rpl_val = (state == VER_REPLY);
  assign o_rpl = sr_beat(rpl_sr[BEAT_BITS-1:0], rpl_first, rpl_left);
  assign rpl_fire = o_rpl_val && i_rpl_rdy;

  always_ff @(posedge i_clk_core) begin
    if (i_rst_core || i_usr_rst) begin
      state <= VER_IDLE;
      job_first <= 1'b0;
    end else begin
      case (state)
        VER_IDLE: begin
          if (cmd_fire && i_cmd.sop && !i_cmd.eop) begin
            state <= (hdr.cmd == CMD_VERIFY) ? VER_INDEX : VER_DISCARD;
          end
        end
        VER_INDEX: begin
          if (cmd_fire) begin
            state <= i_cmd.eop ? VER_IDLE : VER_FEED;
            job_first <= 1'b1;
          end
        end
        VER_FEED: begin
          if (cmd_fire) begin
            job_first <= 1'b0;
            if (i_cmd.eop) state <= VER_WAIT;
          end
        end
        VER_WAIT: if (i_result_val) state <= VER_REPLY;
        VER_REPLY: if (rpl_fire && o_rpl.eop) state <= VER_IDLE;
        VER_DISCARD: if (cmd_fire && i_cmd.eop) state <= VER_IDLE;
        default: state <= VER_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk_core) begin
    if (state == VER_INDEX && cmd_fire) begin
      index_q <= i_cmd.dat;
    end
    if (state == VER_WAIT && i_result_val) begin
      rpl_sr <= ver_rpl;
      rpl_left <= byte_cnt_t'(VERIFY_RPL_BYTES);
      rpl_first <= 1'b1;
    end else if (rpl_fire) begin
      rpl_sr <= rpl_sr >> BEAT_BITS;
      rpl_left <= rpl_left - 8'd8;
      rpl_first <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* list.f */
hw/ctl_stream_pkg.sv
hw/ctl_msg_pkg.sv
hw/cmd_fifo.sv
hw/cmd_router.sv
hw/sys_cmd_proc.sv
hw/verify_cmd_proc.sv
hw/reply_arb.sv
hw/ctl_top.sv
verif/ctl_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the controller testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module ctl_top_tb -f list.f -o ctl_top_tb_sim

./obj_dir/ctl_top_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
  exit 0
fi
exit 1

/* verif/ctl_top_tb.sv */
// Testbench for ctl_top with an engine model, a reply scoreboard and stream assertions
// Replies are matched in order per handler, the header type picks which handler
// Inputs change 2 ns after a rising edge, procedural checks sample on the falling edge
`default_nettype none

module ctl_top_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import ctl_stream_pkg::*;
  import ctl_msg_pkg::*;

  localparam int RST_CYCLES = 8;
  localparam logic [63:0] BUILD_HOST = "tb_host1";
  localparam logic [31:0] BUILD_DATE = 32'h1357_0246;
  localparam int N_CMDS = 16;
  localparam logic [31:0] SEED = 32'd21560;

  logic i_clk_core, i_rst_core;
  ctl_beat_t i_cmd, o_rpl, o_job;
  logic i_cmd_val, o_cmd_rdy, o_rpl_val, i_rpl_rdy, o_job_val, i_job_rdy;
  result_mask_t i_result_mask;
  logic i_result_val, o_usr_rst;

  ctl_beat_t tx_q[$];
  ctl_beat_t exp_sys_rpl[$];
  ctl_beat_t exp_ver_rpl[$];
  ctl_beat_t exp_job[$];
  int eng_delay_q[$];
  result_mask_t eng_mask_q[$];
  ctl_beat_t rpl_exp_b, job_exp_b;
  logic [31:0] stim_seed;
  logic in_pkt = 1'b0;
  // Current reply packet comes from the verify handler
  logic rpl_ver = 1'b0;
  int jobs_ended = 0;
  int jobs_answered = 0;
  int resets_sent = 0;
  int resets_seen = 0;
  int rst_len = 0;
  // Reply ready is high on this many of every 4 cycles
  int rpl_rdy_level = 3;

  ctl_top #(
    .QUEUE_DEPTH(16), .RST_CYCLES(RST_CYCLES), .BUILD_HOST(BUILD_HOST), .BUILD_DATE(BUILD_DATE)
  ) ctl_top_i (
    .i_clk_core(i_clk_core), .i_rst_core(i_rst_core),
    .i_cmd(i_cmd), .i_cmd_val(i_cmd_val), .o_cmd_rdy(o_cmd_rdy),
    .o_rpl(o_rpl), .o_rpl_val(o_rpl_val), .i_rpl_rdy(i_rpl_rdy),
    .o_job(o_job), .o_job_val(o_job_val), .i_job_rdy(i_job_rdy),
    .i_result_mask(i_result_mask), .i_result_val(i_result_val),
    .o_usr_rst(o_usr_rst)
  );

  initial begin
    i_clk_core = 1'b0;
    forever #10 i_clk_core = ~i_clk_core;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] stim_rand();
    stim_seed = xorshift32(stim_seed);
    return stim_seed;
  endfunction

  task automatic stop_failed();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(string name, logic [69:0] exp, logic [69:0] got);
    $display("Error: %s expected %h got %h", name, exp, got);
    stop_failed();
  endtask

  task automatic report_problem(string what);
    $display("%s", what);
    stop_failed();
  endtask

  function automatic ctl_beat_t mk_beat(beat_dat_t dat, logic sop, logic eop, beat_mod_t mod);
    ctl_beat_t b;
    b.dat = dat;
    b.sop = sop;
    b.eop = eop;
    b.mod = mod;
    return b;
  endfunction

  // Header word: len in the low 16 bits, then the command, then zero
  function automatic beat_dat_t hdr_dat(msg_cmd_t cmd, int nbytes);
    return {32'h0, cmd, 16'(nbytes)};
  endfunction

  task automatic expect_status();
    exp_sys_rpl.push_back(mk_beat(hdr_dat(RPL_STATUS, 20), 1'b1, 1'b0, 3'd0));
    exp_sys_rpl.push_back(mk_beat(BUILD_HOST, 1'b0, 1'b0, 3'd0));
    exp_sys_rpl.push_back(mk_beat({32'h0, BUILD_DATE}, 1'b0, 1'b1, 3'd4));
  endtask

  task automatic expect_verify(job_index_t idx, result_mask_t mask);
    exp_ver_rpl.push_back(mk_beat(hdr_dat(RPL_VERIFY, 24), 1'b1, 1'b0, 3'd0));
    exp_ver_rpl.push_back(mk_beat(idx, 1'b0, 1'b0, 3'd0));
    exp_ver_rpl.push_back(mk_beat(64'(mask), 1'b0, 1'b1, 3'd0));
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge i_clk_core);
      #2;
    end
  endtask

  // Offers the queued beats in order, entered and left 2 ns after a rising edge
  task automatic send_packet();
    logic taken;
    while (tx_q.size() != 0) begin
      i_cmd = tx_q.pop_front();
      i_cmd_val = 1'b1;
      taken = 1'b0;
      while (!taken) begin
        @(negedge i_clk_core);
        taken = o_cmd_rdy;
        @(posedge i_clk_core);
        #2;
      end
    end
    i_cmd_val = 1'b0;
  endtask

  task automatic wait_replies();
    while (exp_sys_rpl.size() != 0 || exp_ver_rpl.size() != 0 || exp_job.size() != 0
           || jobs_answered != jobs_ended) begin
      @(posedge i_clk_core);
      #2;
    end
  endtask

  task automatic send_status();
    expect_status();
    tx_q.push_back(mk_beat(hdr_dat(CMD_STATUS, 8), 1'b1, 1'b1, 3'd0));
    send_packet();
  endtask

  task automatic send_reset();
    exp_sys_rpl.push_back(mk_beat(hdr_dat(RPL_RESET, 8), 1'b1, 1'b1, 3'd0));
    resets_sent++;
    tx_q.push_back(mk_beat(hdr_dat(CMD_RESET, 8), 1'b1, 1'b1, 3'd0));
    send_packet();
  endtask

  task automatic send_unknown(msg_cmd_t cmd, int nbeats);
    tx_q.push_back(mk_beat(hdr_dat(cmd, 8 * nbeats), 1'b1, 1'b0, 3'd0));
    for (int i = 1; i < nbeats; i++) begin
      tx_q.push_back(mk_beat({stim_rand(), stim_rand()}, 1'b0, i == nbeats - 1, 3'd0));
    end
    send_packet();
  endtask

  // Header, index, then n payload beats; the engine answers after delay cycles
  task automatic send_verify(int n, int delay,
                             output job_index_t idx, output result_mask_t mask);
    beat_dat_t d;
    beat_mod_t m;
    logic last;
    int nbytes;
    idx = {stim_rand(), stim_rand()};
    mask = result_mask_t'(stim_rand());
    m = beat_mod_t'(stim_rand());
    nbytes = 16 + 8 * (n - 1) + ((m == 3'd0) ? 8 : int'(m));
    tx_q.push_back(mk_beat(hdr_dat(CMD_VERIFY, nbytes), 1'b1, 1'b0, 3'd0));
    tx_q.push_back(mk_beat(idx, 1'b0, 1'b0, 3'd0));
    for (int i = 0; i < n; i++) begin
      d = {stim_rand(), stim_rand()};
      last = (i == n - 1);
      tx_q.push_back(mk_beat(d, 1'b0, last, last ? m : 3'd0));
      exp_job.push_back(mk_beat(d, i == 0, last, last ? m : 3'd0));
    end
    eng_delay_q.push_back(delay);
    eng_mask_q.push_back(mask);
    expect_verify(idx, mask);
    send_packet();
  endtask

  // Reply scoreboard and packet framing
  always @(negedge i_clk_core) begin
    if (!i_rst_core && o_rpl_val && i_rpl_rdy) begin
      assert (o_rpl.sop == !in_pkt)
        else report_problem("Reply packets interleaved or sop missing");
      if (o_rpl.sop) rpl_ver = (o_rpl.dat[31:24] != 8'h00);
      if (rpl_ver && exp_ver_rpl.size() == 0) begin
        report_problem("Verify reply beat appeared when none was expected");
      end else if (!rpl_ver && exp_sys_rpl.size() == 0) begin
        report_problem("System reply beat appeared when none was expected");
      end else begin
        if (rpl_ver) begin
          rpl_exp_b = exp_ver_rpl.pop_front();
        end else begin
          rpl_exp_b = exp_sys_rpl.pop_front();
        end
        assert (o_rpl == rpl_exp_b) else report_mismatch("o_rpl", rpl_exp_b, o_rpl);
      end
      in_pkt = !o_rpl.eop;
    end
  end

  always @(negedge i_clk_core) begin
    if (!i_rst_core && o_job_val && i_job_rdy) begin
      if (exp_job.size() == 0) begin
        report_problem("Job beat appeared with no job payload pending");
      end else begin
        job_exp_b = exp_job.pop_front();
        assert (o_job == job_exp_b) else report_mismatch("o_job", job_exp_b, o_job);
        if (o_job.eop) jobs_ended++;
      end
    end
  end

  // Width of each user reset pulse
  always @(negedge i_clk_core) begin
    if (!i_rst_core) begin
      if (o_usr_rst) begin
        rst_len++;
      end else if (rst_len != 0) begin
        assert (rst_len == RST_CYCLES)
          else report_mismatch("o_usr_rst cycles", 70'(RST_CYCLES), 70'(rst_len));
        resets_seen++;
        rst_len = 0;
      end
    end
  end

  rpl_held: assert property (@(posedge i_clk_core) disable iff (i_rst_core)
      (o_rpl_val && !i_rpl_rdy) |=> (o_rpl_val && $stable(o_rpl)))
    else report_problem("Reply beat changed or dropped while the output was stalled");

  job_held: assert property (@(posedge i_clk_core) disable iff (i_rst_core)
      (o_job_val && !i_job_rdy) |=> (o_job_val && $stable(o_job)))
    else report_problem("Job beat changed or dropped while the engine stalled");

  rst_quiet: assert property (@(posedge i_clk_core) disable iff (i_rst_core)
      o_usr_rst |-> !o_rpl_val)
    else report_problem("Reply offered while the user reset was high");

  // Engine model, one strobe per finished job
  initial begin
    int delay;
    result_mask_t mask;
    i_result_val = 1'b0;
    i_result_mask = '0;
    forever begin
      @(posedge i_clk_core);
      if (jobs_ended > jobs_answered) begin
        if (eng_delay_q.size() == 0) begin
          report_problem("Engine got a job that the test did not announce");
        end else begin
          delay = eng_delay_q.pop_front();
          mask = eng_mask_q.pop_front();
          repeat (delay) @(posedge i_clk_core);
          #2;
          i_result_mask = mask;
          i_result_val = 1'b1;
          @(posedge i_clk_core);
          #2;
          i_result_val = 1'b0;
          jobs_answered++;
        end
      end
    end
  end

  // Random ready patterns for the reply and job streams
  initial begin
    logic [31:0] bp_seed;
    bp_seed = xorshift32(SEED);
    i_rpl_rdy = 1'b1;
    i_job_rdy = 1'b1;
    forever begin
      @(posedge i_clk_core);
      #2;
      bp_seed = xorshift32(bp_seed);
      i_rpl_rdy = ({1'b0, bp_seed[1:0]} < 3'(rpl_rdy_level));
      bp_seed = xorshift32(bp_seed);
      i_job_rdy = (bp_seed[1:0] != 2'd0);
    end
  end

  initial begin
    repeat (N_CMDS * 400) @(posedge i_clk_core);
    report_problem("Watchdog timeout, the commands did not complete in time");
  end

  initial begin
    job_index_t idx;
    result_mask_t mask;
    stim_seed = SEED;
    i_cmd = '0;
    i_cmd_val = 1'b0;
    i_rst_core = 1'b1;
    repeat (4) @(posedge i_clk_core);
    #2;
    i_rst_core = 1'b0;
    @(negedge i_clk_core);
    assert (o_cmd_rdy === 1'b1 && o_rpl_val === 1'b0 && o_job_val === 1'b0
            && o_usr_rst === 1'b0)
      else report_problem("Outputs are not idle after reset");
    idle(1);

    send_status();
    wait_replies();
    send_reset();
    wait_replies();

    // Payloads of one, two and four beats
    send_verify(1, int'(stim_rand() % 32'd16), idx, mask);
    wait_replies();
    send_verify(2, int'(stim_rand() % 32'd16), idx, mask);
    wait_replies();
    send_verify(4, int'(stim_rand() % 32'd16), idx, mask);
    wait_replies();

    // Unknown commands are dropped and the next one still works
    send_unknown(16'h0042, 3);
    send_status();
    wait_replies();
    send_unknown(16'h01ff, 3);
    send_verify(2, int'(stim_rand() % 32'd16), idx, mask);
    wait_replies();

    // Heavy reply back-pressure with queued commands from both handlers
    rpl_rdy_level = 1;
    send_status();
    send_status();
    send_status();
    send_verify(3, int'(stim_rand() % 32'd16), idx, mask);
    send_verify(2, int'(stim_rand() % 32'd16), idx, mask);
    wait_replies();
    rpl_rdy_level = 3;

    // Status overtakes a verify job held up by a slow engine
    send_verify(2, 80, idx, mask);
    send_status();
    while (exp_sys_rpl.size() != 0) begin
      @(posedge i_clk_core);
      #2;
    end
    if (exp_ver_rpl.size() != 3) begin
      report_problem("Verify reply came out before the status reply");
    end
    wait_replies();

    idle(20);
    if (exp_sys_rpl.size() == 0 && exp_ver_rpl.size() == 0 && exp_job.size() == 0
        && resets_seen == resets_sent) begin
      $display("All tests passed");
      $finish;
    end else begin
      report_problem("Replies, job beats or reset pulses left unmatched at the end");
    end
  end

endmodule

`default_nettype wire
